//--- Makefile
VERILATOR ?= verilator
TOP ?= convolveTb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- convolve.sv
`timescale 1ns/1ns
`default_nettype none

module convolve #(
	parameter int vecLen = 40,
	parameter g729Pkg::regionId inputBase = 5'd0,
	parameter g729Pkg::regionId impulseBase = 5'd1,
	parameter g729Pkg::regionId outputBase = 5'd2
)
(
	input wire clk,
	input wire reset,
	input wire start,
	output logic busy,
	output logic done,
	memBus.requester bus,
	output logic macValid,
	output g729Pkg::word16 macA,
	output g729Pkg::word16 macB,
	output g729Pkg::word32 macAcc,
	input wire g729Pkg::word32 macResult,
	output logic shiftStart,
	output g729Pkg::word32 shiftIn,
	input wire g729Pkg::word32 shiftOut,
	input wire shiftDone
);
	import g729Pkg::*;

	localparam vecIndex lastIndex = vecIndex'(vecLen - 1);

	convState state;
	convState nextState;
	vecIndex n;
	vecIndex i;
	word32 sum;
	word16 xHeld;

	////////////////////////////////////////////////////////////
	// State and loop counters

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			n <= '0;
			i <= '0;
			done <= 1'b0;
		end
		else
		begin
			state <= nextState;
			// Pulse lands on the first idle cycle
			done <= (state == finish);
			case (state)
				idle:
					n <= '0;
				outerLoop:
					i <= '0;
				macWait:
					if (i != n)
						i <= i + 1'b1;
				writeY:
					if (n != lastIndex)
						n <= n + 1'b1;
				default:
					;
			endcase
		end
	end

	// Running sum and held x sample
	always_ff @(posedge clk)
	begin
		case (state)
			outerLoop:
				sum <= '0;
			readX:
				xHeld <= bus.readData[15:0];
			macWait:
				sum <= macResult;
			shiftWait:
				if (shiftDone)
					sum <= shiftOut;
			default:
				;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Next state and memory strobes

	always_comb
	begin
		nextState = state;
		bus.addr = '0;
		bus.writeEn = 1'b0;
		bus.writeData = '0;
		macValid = 1'b0;
		shiftStart = 1'b0;
		case (state)
			idle:
				if (start)
					nextState = outerLoop;
			outerLoop:
				nextState = innerLoop;
			innerLoop:
			begin
				bus.addr = {inputBase, i};
				nextState = readX;
			end
			readX:
			begin
				// h[n-i]
				bus.addr = {impulseBase, vecIndex'(n - i)};
				nextState = readH;
			end
			readH:
			begin
				macValid = 1'b1;
				nextState = macWait;
			end
			macWait:
				nextState = (i == n) ? g729Pkg::shiftStart : innerLoop;
			g729Pkg::shiftStart:
			begin
				shiftStart = 1'b1;
				nextState = shiftWait;
			end
			shiftWait:
				if (shiftDone)
					nextState = writeY;
			writeY:
			begin
				// extract_h into the upper half
				bus.addr = {outputBase, n};
				bus.writeEn = 1'b1;
				bus.writeData = {sum[31:16], 16'h0000};
				nextState = (n == lastIndex) ? finish : outerLoop;
			end
			default:
				nextState = idle;
		endcase
	end

	// h arrives straight off the bus in readH
	assign macA = xHeld;
	assign macB = bus.readData[15:0];
	assign macAcc = sum;
	assign shiftIn = sum;
	assign busy = (state != idle);

endmodule

`default_nettype wire

//--- convolveTb.sv
`timescale 1ns/1ns
`default_nettype none

module convolveTb;
	import g729Pkg::*;

	// Six engine runs of about 3600 cycles, plus loading and readback
	localparam int timeoutCycles = 40000;
	// One run at vecLen 64 stays under this
	localparam int runLimit = 9000;
	localparam longint maxWord = 64'sh7fff_ffff;
	localparam longint minWord = -64'sh8000_0000;

	logic clk;
	logic reset;
	logic start;
	logic busy;
	logic done;
	memAddr hostAddr;
	logic hostWriteEn;
	word32 hostWriteData;
	word32 hostReadData;
	logic hostGrant;

	int vecLen;
	int shiftAmount;
	regionId inBase;
	regionId hBase;
	regionId yBase;
	word16 xVec [64];
	word16 hVec [64];
	word16 expY [64];
	int doneCount;
	int cycleCount;

	convolveTop i_convolveTop
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.busy(busy),
		.done(done),
		.hostAddr(hostAddr),
		.hostWriteEn(hostWriteEn),
		.hostWriteData(hostWriteData),
		.hostReadData(hostReadData),
		.hostGrant(hostGrant)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Global cycle limit
	initial
	begin
		cycleCount = 0;
		while (cycleCount < timeoutCycles)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Simulation ran past %0d cycles without finishing", timeoutCycles);
		$display("TEST FAILED");
		$fatal(1, "timeout");
	end

	always @(negedge clk)
	begin
		if (done === 1'b1)
			doneCount++;
	end

	////////////////////////////////////////////////////////////
	// Failure reporting and compares

	task automatic reportFailure(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "check failed");
	endtask

	task automatic compareWord16(input string name, input word16 expected, input word16 actual);
		if (actual !== expected)
			reportFailure($sformatf("[FAIL] t=%0t %s expected %h actual %h",
				$time, name, expected, actual));
	endtask

	task automatic compareBit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			reportFailure($sformatf("[FAIL] t=%0t %s expected %b actual %b",
				$time, name, expected, actual));
	endtask

	////////////////////////////////////////////////////////////
	// Reference model from the basic operator rules

	function automatic longint clampWord(input longint v);
		if (v > maxWord)
			return maxWord;
		if (v < minWord)
			return minWord;
		return v;
	endfunction

	// L_mac, doubled product then saturating add
	function automatic longint macStep(input longint acc, input word16 a, input word16 b);
		longint prod;
		prod = clampWord(longint'(a) * longint'(b) * 2);
		return clampWord(acc + prod);
	endfunction

	// L_shl, clamps by the original sign once a shift overflows
	function automatic longint shiftSat(input longint v, input int amount);
		longint r;
		r = v;
		for (int k = 0; k < amount; k++)
		begin
			if (r > 64'sh3fff_ffff || r < -64'sh4000_0000)
				return (v < 0) ? minWord : maxWord;
			r = r * 2;
		end
		return r;
	endfunction

	task automatic modelConvolve();
		longint acc;
		word32 w;
		for (int n = 0; n < vecLen; n++)
		begin
			acc = 0;
			for (int i = 0; i <= n; i++)
				acc = macStep(acc, xVec[i], hVec[n - i]);
			w = word32'(shiftSat(acc, shiftAmount));
			expY[n] = w[31:16];
		end
	endtask

	////////////////////////////////////////////////////////////
	// Host port and engine control

	task automatic waitGrant();
		@(negedge clk);
		while (hostGrant !== 1'b1)
			@(negedge clk);
	endtask

	task automatic hostWrite(input memAddr addr, input word32 data);
		waitGrant();
		@(posedge clk);
		hostAddr <= addr;
		hostWriteEn <= 1'b1;
		hostWriteData <= data;
		@(posedge clk);
		hostWriteEn <= 1'b0;
	endtask

	task automatic hostRead(input memAddr addr, output word32 data);
		waitGrant();
		@(posedge clk);
		hostAddr <= addr;
		hostWriteEn <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		data = hostReadData;
	endtask

	// x, h and a per-index marker in the y region
	task automatic loadVectors();
		for (int k = 0; k < vecLen; k++)
		begin
			hostWrite({inBase, vecIndex'(k)}, {16'h0000, xVec[k]});
			hostWrite({hBase, vecIndex'(k)}, {16'h0000, hVec[k]});
			hostWrite({yBase, vecIndex'(k)}, {16'hdead + 16'(k), 16'hbeef});
		end
		modelConvolve();
	endtask

	task automatic pulseStart();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic waitDone();
		int waited;
		waited = 0;
		@(negedge clk);
		while (done !== 1'b1)
		begin
			if (waited == runLimit)
				reportFailure("Engine never raised done within the run limit");
			waited++;
			@(negedge clk);
		end
		compareBit("busy", 1'b0, busy);
	endtask

	task automatic runEngine();
		pulseStart();
		@(negedge clk);
		compareBit("busy", 1'b1, busy);
		compareBit("hostGrant", 1'b0, hostGrant);
		waitDone();
	endtask

	task automatic checkOutputs();
		word32 data;
		for (int n = 0; n < vecLen; n++)
		begin
			hostRead({yBase, vecIndex'(n)}, data);
			compareWord16($sformatf("y[%0d]", n), expY[n], data[31:16]);
			compareWord16($sformatf("y[%0d] low half", n), 16'h0000, data[15:0]);
		end
	endtask

	task automatic fillRandom(input int hShift);
		for (int k = 0; k < vecLen; k++)
		begin
			xVec[k] = word16'($urandom);
			hVec[k] = word16'($urandom) >>> hShift;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests

	task automatic testImpulse();
		for (int k = 0; k < vecLen; k++)
		begin
			xVec[k] = (k == 0) ? 16'sh4000 : 16'sh0000;
			hVec[k] = word16'($urandom) >>> 5;
		end
		loadVectors();
		runEngine();
		checkOutputs();
	endtask

	// Narrow h gives a mix of clean and saturated sums
	task automatic testRandom();
		fillRandom(4);
		loadVectors();
		runEngine();
		checkOutputs();
	endtask

	task automatic testSaturation();
		for (int k = 0; k < vecLen; k++)
		begin
			xVec[k] = 16'sh8000;
			hVec[k] = 16'sh8000;
		end
		loadVectors();
		runEngine();
		checkOutputs();
	endtask

	task automatic testHostBlocking();
		word32 data;
		fillRandom(4);
		loadVectors();
		pulseStart();
		for (int k = 0; k < 8; k++)
		begin
			@(posedge clk);
			hostAddr <= {inBase, vecIndex'(k)};
			hostWriteEn <= 1'b1;
			hostWriteData <= {16'hffff, ~xVec[k]};
			@(negedge clk);
			compareBit("hostGrant", 1'b0, hostGrant);
		end
		@(posedge clk);
		hostWriteEn <= 1'b0;
		waitDone();
		for (int k = 0; k < 8; k++)
		begin
			hostRead({inBase, vecIndex'(k)}, data);
			compareWord16($sformatf("x[%0d]", k), xVec[k], data[15:0]);
			compareWord16($sformatf("x[%0d] high half", k), 16'h0000, data[31:16]);
		end
		checkOutputs();
	endtask

	task automatic testBackToBack();
		@(posedge clk);
		doneCount = 0;
		fillRandom(3);
		loadVectors();
		pulseStart();
		repeat (100) @(posedge clk);
		// Ignored while busy
		pulseStart();
		waitDone();
		// A latched extra start would restart the engine here
		@(negedge clk);
		compareBit("busy", 1'b0, busy);
		checkOutputs();
		fillRandom(5);
		loadVectors();
		runEngine();
		checkOutputs();
		if (doneCount != 2)
			reportFailure($sformatf("Expected two done pulses but saw %0d", doneCount));
	endtask

	initial
	begin
		void'($urandom(32'hb3bb_8f9d));
		vecLen = i_convolveTop.vecLen;
		shiftAmount = i_convolveTop.shiftAmount;
		inBase = i_convolveTop.inputBase;
		hBase = i_convolveTop.impulseBase;
		yBase = i_convolveTop.outputBase;
		doneCount = 0;
		reset = 1'b1;
		start = 1'b0;
		hostAddr = '0;
		hostWriteEn = 1'b0;
		hostWriteData = '0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		compareBit("busy", 1'b0, busy);
		compareBit("done", 1'b0, done);
		compareBit("hostGrant", 1'b1, hostGrant);

		testImpulse();
		testRandom();
		testSaturation();
		testHostBlocking();
		testBackToBack();

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- convolveTop.sv
`timescale 1ns/1ns
`default_nettype none

module convolveTop #(
	parameter int vecLen = 40,
	parameter int shiftAmount = 3,
	parameter g729Pkg::regionId inputBase = 5'd0,
	parameter g729Pkg::regionId impulseBase = 5'd1,
	parameter g729Pkg::regionId outputBase = 5'd2
)
(
	input wire clk,
	input wire reset,
	input wire start,
	output logic busy,
	output logic done,
	input wire g729Pkg::memAddr hostAddr,
	input wire hostWriteEn,
	input wire g729Pkg::word32 hostWriteData,
	output g729Pkg::word32 hostReadData,
	output logic hostGrant
);
	import g729Pkg::*;

	memBus engineBus ();
	memBus hostBus ();

	memAddr memAddrOut;
	logic memWriteEn;
	word32 memWriteData;
	word32 memReadData;

	logic macValid;
	word16 macA;
	word16 macB;
	word32 macAcc;
	word32 macResult;
	logic shiftPulse;
	word32 shiftIn;
	word32 shiftOut;
	logic shiftDone;

	////////////////////////////////////////////////////////////
	// Host port onto its bus

	assign hostBus.addr = hostAddr;
	assign hostBus.writeEn = hostWriteEn;
	assign hostBus.writeData = hostWriteData;
	assign hostReadData = hostBus.readData;

	scratchMem i_scratchMem
	(
		.clk(clk),
		.addr(memAddrOut),
		.writeEn(memWriteEn),
		.writeData(memWriteData),
		.readData(memReadData)
	);

	memArbiter i_memArbiter
	(
		.clk(clk),
		.reset(reset),
		.busy(busy),
		.engineBus(engineBus),
		.hostBus(hostBus),
		.memAddrOut(memAddrOut),
		.memWriteEn(memWriteEn),
		.memWriteData(memWriteData),
		.memReadData(memReadData),
		.hostGrant(hostGrant)
	);

	lMac i_lMac
	(
		.clk(clk),
		.reset(reset),
		.macValid(macValid),
		.macA(macA),
		.macB(macB),
		.macAcc(macAcc),
		.macResult(macResult)
	);

	lShl #(
		.shiftAmount(shiftAmount)
	) i_lShl
	(
		.clk(clk),
		.reset(reset),
		.shiftStart(shiftPulse),
		.shiftIn(shiftIn),
		.shiftOut(shiftOut),
		.shiftDone(shiftDone)
	);

	convolve #(
		.vecLen(vecLen),
		.inputBase(inputBase),
		.impulseBase(impulseBase),
		.outputBase(outputBase)
	) i_convolve
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.busy(busy),
		.done(done),
		.bus(engineBus),
		.macValid(macValid),
		.macA(macA),
		.macB(macB),
		.macAcc(macAcc),
		.macResult(macResult),
		.shiftStart(shiftPulse),
		.shiftIn(shiftIn),
		.shiftOut(shiftOut),
		.shiftDone(shiftDone)
	);

endmodule

`default_nettype wire

//--- convolveTop_assert.sv
`timescale 1ns/1ns
`default_nettype none

module convolveTopAssert
(
	input wire clk,
	input wire reset,
	input wire busy,
	input wire done,
	input wire hostGrant,
	input wire memWriteEn,
	input wire g729Pkg::memAddr memAddrOut,
	input wire g729Pkg::regionId outputRegion
);

	assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else $error("done stayed high for more than one cycle");

	assert property (@(posedge clk) disable iff (reset) busy |-> !hostGrant)
		else $error("hostGrant high while the engine is busy");

	// Host writes are masked while busy, so any write here is the engine's
	assert property (@(posedge clk) disable iff (reset)
		(busy && memWriteEn) |-> (memAddrOut[10:6] == outputRegion))
		else $error("engine wrote outside the output region");

endmodule

bind convolveTop convolveTopAssert i_convolveTopAssert
(
	.clk(clk),
	.reset(reset),
	.busy(busy),
	.done(done),
	.hostGrant(hostGrant),
	.memWriteEn(memWriteEn),
	.memAddrOut(memAddrOut),
	.outputRegion(outputBase)
);

`default_nettype wire

//--- g729Pkg.sv
`default_nettype none

package g729Pkg;

	////////////////////////////////////////////////////////////
	// Data words

	// Q15 sample for x, h and y
	typedef logic signed [15:0] word16;

	// Accumulator and memory word
	typedef logic signed [31:0] word32;

	////////////////////////////////////////////////////////////
	// Scratch memory addressing

	typedef logic [10:0] memAddr;

	// Upper address bits pick the vector region
	typedef logic [4:0] regionId;

	// Lower address bits, also the loop counter width
	typedef logic [5:0] vecIndex;

	////////////////////////////////////////////////////////////
	// Engine FSM

	typedef enum logic [3:0]
	{
		idle,
		outerLoop,
		innerLoop,
		readX,
		readH,
		macWait,
		shiftStart,
		shiftWait,
		writeY,
		finish
	} convState;

endpackage

`default_nettype wire

//--- lMac.sv
`timescale 1ns/1ns
`default_nettype none

module lMac
(
	input wire clk,
	input wire reset,
	input wire macValid,
	input wire g729Pkg::word16 macA,
	input wire g729Pkg::word16 macB,
	input wire g729Pkg::word32 macAcc,
	output g729Pkg::word32 macResult
);
	import g729Pkg::*;

	word32 product;
	word32 doubled;
	logic signed [32:0] wideSum;
	word32 satSum;

	always_comb
	begin
		product = macA * macB;
		// L_mult overflows only for 8000 x 8000
		if (product == 32'sh4000_0000)
			doubled = 32'sh7fff_ffff;
		else
			doubled = product <<< 1;
		// L_add with saturation
		wideSum = {doubled[31], doubled} + {macAcc[31], macAcc};
		if (wideSum[32] != wideSum[31])
			satSum = wideSum[32] ? 32'sh8000_0000 : 32'sh7fff_ffff;
		else
			satSum = wideSum[31:0];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			macResult <= '0;
		else if (macValid)
			macResult <= satSum;
	end

endmodule

`default_nettype wire

//--- lShl.sv
`timescale 1ns/1ns
`default_nettype none

module lShl #(
	parameter int shiftAmount = 3
)
(
	input wire clk,
	input wire reset,
	input wire shiftStart,
	input wire g729Pkg::word32 shiftIn,
	output g729Pkg::word32 shiftOut,
	output logic shiftDone
);
	import g729Pkg::*;

	word32 shiftReg;
	logic [5:0] count;
	logic active;
	logic saturated;
	logic negative;

	////////////////////////////////////////////////////////////
	// Step counter, done one cycle after the last shift

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			active <= 1'b0;
			count <= '0;
		end
		else if (shiftStart)
		begin
			active <= 1'b1;
			count <= 6'(shiftAmount);
		end
		else if (active)
		begin
			if (count == '0)
				active <= 1'b0;
			else
				count <= count - 1'b1;
		end
	end

	// One bit per step, sign change latches saturation
	always_ff @(posedge clk)
	begin
		if (shiftStart)
		begin
			shiftReg <= shiftIn;
			negative <= shiftIn[31];
			saturated <= 1'b0;
		end
		else if (active && count != '0)
		begin
			shiftReg <= shiftReg << 1;
			if (shiftReg[31] != shiftReg[30])
				saturated <= 1'b1;
		end
	end

	assign shiftDone = active && (count == '0);
	assign shiftOut = !saturated ? shiftReg :
		(negative ? 32'sh8000_0000 : 32'sh7fff_ffff);

endmodule

`default_nettype wire

//--- memArbiter.sv
`timescale 1ns/1ns
`default_nettype none

module memArbiter
(
	input wire clk,
	input wire reset,
	input wire busy,
	memBus.arbiter engineBus,
	memBus.arbiter hostBus,
	output g729Pkg::memAddr memAddrOut,
	output logic memWriteEn,
	output g729Pkg::word32 memWriteData,
	input wire g729Pkg::word32 memReadData,
	output logic hostGrant
);
	logic engineHeld;
	logic engineOwns;

	// Ownership register, engine keeps the port one cycle past busy
	always_ff @(posedge clk)
	begin
		if (reset)
			engineHeld <= 1'b0;
		else
			engineHeld <= busy;
	end

	// Engine wins from the first busy cycle on
	assign engineOwns = busy | engineHeld;
	assign hostGrant = ~engineOwns;

	////////////////////////////////////////////////////////////
	// Port mux, host writes fall on the floor while engine owns

	always_comb
	begin
		if (engineOwns)
		begin
			memAddrOut = engineBus.addr;
			memWriteEn = engineBus.writeEn;
			memWriteData = engineBus.writeData;
		end
		else
		begin
			memAddrOut = hostBus.addr;
			memWriteEn = hostBus.writeEn;
			memWriteData = hostBus.writeData;
		end
	end

	// Both sides see every read word
	assign engineBus.readData = memReadData;
	assign hostBus.readData = memReadData;

endmodule

`default_nettype wire

//--- memBus.sv
`timescale 1ns/1ns
`default_nettype none

// One port into the scratch memory, read data one cycle after addr
interface memBus;
	import g729Pkg::*;

	memAddr addr;
	logic writeEn;
	word32 writeData;
	word32 readData;

	modport requester
	(
		output addr,
		output writeEn,
		output writeData,
		input readData
	);

	modport arbiter
	(
		input addr,
		input writeEn,
		input writeData,
		output readData
	);

endinterface

`default_nettype wire

//--- scratchMem.sv
`timescale 1ns/1ns
`default_nettype none

module scratchMem
(
	input wire clk,
	input wire g729Pkg::memAddr addr,
	input wire writeEn,
	input wire g729Pkg::word32 writeData,
	output g729Pkg::word32 readData
);
	import g729Pkg::*;

	localparam int depth = 2048;

	// 32 regions of 64 words
	word32 mem [depth];

	////////////////////////////////////////////////////////////
	// Single port, write first in the array, read returns old word

	always_ff @(posedge clk)
	begin
		if (writeEn)
		begin
			mem[addr] <= writeData;
		end
		readData <= mem[addr];
	end

endmodule

`default_nettype wire

//--- sim.f
g729Pkg.sv
memBus.sv
scratchMem.sv
memArbiter.sv
lMac.sv
lShl.sv
convolve.sv
convolveTop.sv
convolveTop_assert.sv
convolveTb.sv
